//--- vlog.f
src/hyper_pkg.sv
src/hyper_lane.sv
src/hyper_rx_fifo.sv
src/hyper_lane_join.sv
src/hyper_phy_if.sv
tb/tb_hyper_mem.sv
tb/tb_hyper_phy_if.sv

//--- Bender.yml
package:
  name: hyper_phy_if

sources:
  - src/hyper_pkg.sv
  - src/hyper_lane.sv
  - src/hyper_rx_fifo.sv
  - src/hyper_lane_join.sv
  - src/hyper_phy_if.sv
  - target: simulation
    files:
      - tb/tb_hyper_mem.sv
      - tb/tb_hyper_phy_if.sv

//--- tb/tb_hyper_phy_if.sv
// Testbench for the two-lane HyperBus controller; runs bursts against two lane devices
`timescale 1ns/1ps

module tb_hyper_phy_if;
    import hyper_pkg::*;

    logic                     clk_i;
    logic                     arst_n_i;
    hyper_cfg_t               cfg_i;
    logic                     trans_valid_i;
    logic                     trans_ready_o;
    hyper_tf_t                trans_i;
    logic [NumChips-1:0]      trans_cs_i;
    logic                     tx_valid_i;
    logic                     tx_ready_o;
    hyper_tx_t                tx_i;
    logic                     rx_valid_o;
    logic                     rx_ready_i;
    hyper_rx_t                rx_o;
    logic                     b_valid_o;
    logic                     b_ready_i;
    logic                     b_error_o;
    logic [1:0][NumChips-1:0] hyper_cs_no;
    logic [1:0]               hyper_ck_o;
    logic [1:0]               hyper_rwds_o;
    logic [1:0]               hyper_rwds_i;
    logic [1:0]               hyper_rwds_oe_o;
    logic [1:0][7:0]          hyper_dq_o;
    logic [1:0][7:0]          hyper_dq_i;
    logic [1:0]               hyper_dq_oe_o;
    logic [1:0]               hyper_reset_no;

    logic [31:0] lfsr_q;
    logic [31:0] shadow_q [64];
    hyper_rx_t   exp_q [64];
    hyper_rx_t   exp_now;
    int unsigned exp_cnt;
    int unsigned rd_idx;
    int unsigned b_cnt;
    logic        exp_b_err;
    logic        rand_ready = 1'b0;
    int unsigned cycles = 0;
    int unsigned cycle_limit;

    hyper_phy_if uut (.*);

    for (genvar i = 0; i < 2; i++) begin : g_mem
        tb_hyper_mem i_mem (
            .clk_i     (clk_i),
            .arst_n_i  (arst_n_i),
            .latency_i (cfg_i.latency),
            .cs_ni     (hyper_cs_no[i][0]),
            .ck_i      (hyper_ck_o[i]),
            .rwds_i    (hyper_rwds_o[i]),
            .rwds_oe_i (hyper_rwds_oe_o[i]),
            .rwds_o    (hyper_rwds_i[i]),
            .dq_i      (hyper_dq_o[i]),
            .dq_oe_i   (hyper_dq_oe_o[i]),
            .dq_o      (hyper_dq_i[i])
        );
    end

    always #2 clk_i = ~clk_i;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int unsigned n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int unsigned i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            bits   = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    assign exp_now = exp_q[rd_idx % 64];

    always @(negedge clk_i) begin
        rx_ready_i <= rand_ready ? (take_bits(1) != 0) : 1'b1;
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_idx <= 0;
            b_cnt  <= 0;
        end else begin
            if (rx_valid_o && rx_ready_i) begin
                rd_idx <= rd_idx + 1;
            end
            if (b_valid_o && b_ready_i) begin
                b_cnt <= b_cnt + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rx_valid_o && rx_ready_i) |-> (rd_idx < exp_cnt))
        else report_error("a read beat arrived that was not expected");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rx_valid_o && rx_ready_i) |-> (rx_o.last == exp_now.last
            && rx_o.error == exp_now.error && (exp_now.error || rx_o.data == exp_now.data)))
        else report_error($sformatf("read beat %h/%b/%b, expected %h/%b/%b",
            $sampled(rx_o.data), $sampled(rx_o.last), $sampled(rx_o.error),
            $sampled(exp_now.data), $sampled(exp_now.last), $sampled(exp_now.error)));
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rx_valid_o && !rx_ready_i) |=> (rx_valid_o && $stable(rx_o)))
        else report_error("rx_o changed or dropped before it was accepted");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (b_valid_o && b_ready_i) |-> (b_error_o == exp_b_err))
        else report_error($sformatf("b_error_o %b, expected %b", $sampled(b_error_o),
            $sampled(exp_b_err)));
    // Lanes share chip selects and command bytes
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (hyper_cs_no[0] == hyper_cs_no[1]) && (!(hyper_dq_oe_o[0] && !hyper_rwds_oe_o[0])
            || hyper_dq_o[0] == hyper_dq_o[1]))
        else report_error("lanes differ in chip select or command byte");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(&hyper_cs_no[0] && hyper_ck_o[0]) && !(&hyper_cs_no[1] && hyper_ck_o[1]))
        else report_error("bus clock high while no chip is selected");
    // Controller drives nothing while deselected or while the device answers
    assert property (@(posedge clk_i)
        !((&hyper_cs_no[0] || hyper_rwds_i[0]) && (hyper_dq_oe_o[0] || hyper_rwds_oe_o[0]))
            && !((&hyper_cs_no[1] || hyper_rwds_i[1])
            && (hyper_dq_oe_o[1] || hyper_rwds_oe_o[1])))
        else report_error("output enable high while the controller must not drive the bus");
    assert property (@(posedge clk_i) hyper_reset_no == {2{arst_n_i}})
        else report_error("device reset does not follow the system reset");

    task automatic send_trans(input logic is_write, input addr_t addr, input burst_t burst,
                              input logic [NumChips-1:0] cs);
        cycle_limit += CaBytes + cfg_i.latency + cfg_i.timeout + 8 * (burst + 1) + 16;
        trans_i       = '{write: is_write, addr: addr, burst: burst};
        trans_cs_i    = cs;
        trans_valid_i = 1'b1;
        while (!trans_ready_o) @(negedge clk_i);
        @(negedge clk_i);
        trans_valid_i = 1'b0;
    endtask

    // Last goes out on beat last_beat; anything short of the burst is an error
    task automatic write_burst(input addr_t addr, input burst_t burst,
                               input int unsigned last_beat, input logic rand_strb);
        hyper_tx_t   beat;
        int unsigned b_start;
        b_start   = b_cnt;
        exp_b_err = (last_beat != burst);
        send_trans(1'b1, addr, burst, 2'b01);
        for (int unsigned i = 0; i <= last_beat; i++) begin
            beat.data  = take_bits(32);
            beat.strb  = rand_strb ? 4'(take_bits(4)) : 4'hf;
            beat.last  = (i == last_beat);
            tx_i       = beat;
            tx_valid_i = 1'b1;
            while (!tx_ready_o) @(negedge clk_i);
            @(negedge clk_i);
            for (int b = 0; b < 4; b++) begin
                if (beat.strb[b]) begin
                    shadow_q[(addr + i) % 64][8*b +: 8] = beat.data[8*b +: 8];
                end
            end
        end
        tx_valid_i = 1'b0;
        while (b_cnt == b_start) @(negedge clk_i);
    endtask

    // Chip 1 is not populated, so its beats all carry the error flag
    task automatic read_burst(input logic [NumChips-1:0] cs, input addr_t addr,
                              input burst_t burst);
        logic err;
        err = cs[1];
        for (int unsigned i = 0; i <= burst; i++) begin
            exp_q[exp_cnt % 64] = '{data: err ? 32'h0 : shadow_q[(addr + i) % 64],
                                    last: (i == burst), error: err};
            exp_cnt++;
        end
        send_trans(1'b0, addr, burst, cs);
        while (rd_idx != exp_cnt) @(negedge clk_i);
    endtask

    initial begin
        clk_i         = 1'b0;
        arst_n_i      = 1'b0;
        cfg_i         = '{latency: 4'd3, timeout: 8'd16};
        trans_valid_i = 1'b0;
        trans_i       = '0;
        trans_cs_i    = '0;
        tx_valid_i    = 1'b0;
        tx_i          = '0;
        rx_ready_i    = 1'b1;
        b_ready_i     = 1'b1;
        lfsr_q        = 32'ha6cc_df18;
        exp_cnt       = 0;
        exp_b_err     = 1'b0;
        cycle_limit   = 32;
        repeat (3) @(negedge clk_i);
        arst_n_i = 1'b1;
        @(negedge clk_i);

        write_burst(32'd0, 8'd7, 7, 1'b0);
        write_burst(32'd8, 8'd3, 3, 1'b0);
        read_burst(2'b01, 32'd0, 8'd7);
        read_burst(2'b01, 32'd8, 8'd3);
        // Partial strobes over words written above
        write_burst(32'd2, 8'd3, 3, 1'b1);
        read_burst(2'b01, 32'd0, 8'd7);
        rand_ready <= 1'b1;
        read_burst(2'b01, 32'd0, 8'd11);
        rand_ready <= 1'b0;
        read_burst(2'b10, 32'd4, 8'd3);
        write_burst(32'd16, 8'd3, 1, 1'b0);
        write_burst(32'd16, 8'd3, 3, 1'b0);
        read_burst(2'b01, 32'd16, 8'd3);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- tb/tb_hyper_mem.sv
// Behavioral HyperBus device for one lane; answers chip select 0 from a byte-wide memory
`timescale 1ns/1ps

module tb_hyper_mem (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic [3:0] latency_i,
    input  logic       cs_ni,
    input  logic       ck_i,
    input  logic       rwds_i,
    input  logic       rwds_oe_i,
    output logic       rwds_o,
    input  logic [7:0] dq_i,
    input  logic       dq_oe_i,
    output logic [7:0] dq_o
);
    import hyper_pkg::*;

    logic [7:0]  mem_q [256];
    logic [47:0] ca_q;
    logic [7:0]  cnt_q;
    logic [7:0]  idx_q;
    logic        data_phase;
    logic [7:0]  byte_addr;
    logic [7:0]  dq_seen;
    logic        rwds_seen;

    // Undriven bus lines read as unknown
    assign dq_seen   = dq_oe_i ? dq_i : 8'hxx;
    assign rwds_seen = rwds_oe_i ? rwds_i : 1'bx;

    // Command layout is write flag, pad, word address, burst
    assign data_phase = !cs_ni && (cnt_q >= CaBytes + latency_i);
    assign byte_addr  = {ca_q[14:8], 1'b0} + idx_q;
    assign rwds_o     = data_phase && !ca_q[47];
    assign dq_o       = rwds_o ? mem_q[byte_addr] : 8'h00;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem_q[i] = 8'(i * 37 + 11);
        end
    end

    // Masked bytes are left alone
    always @(posedge clk_i) begin
        if (ck_i && data_phase && ca_q[47] && !rwds_seen) begin
            mem_q[byte_addr] <= dq_seen;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ca_q  <= '0;
            cnt_q <= '0;
            idx_q <= '0;
        end else if (cs_ni) begin
            cnt_q <= '0;
            idx_q <= '0;
        end else if (ck_i) begin
            if (data_phase) begin
                idx_q <= idx_q + 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q < CaBytes) begin
                    ca_q <= {ca_q[39:0], dq_seen};
                end
            end
        end
    end

endmodule

//--- src/hyper_phy_if.sv
// Top level of the two-lane HyperBus controller; 32-bit channels in, two lane buses out
`timescale 1ns/1ps

module hyper_phy_if (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    input  hyper_pkg::hyper_cfg_t                 cfg_i,
    input  logic                                  trans_valid_i,
    output logic                                  trans_ready_o,
    input  hyper_pkg::hyper_tf_t                  trans_i,
    input  logic [hyper_pkg::NumChips-1:0]        trans_cs_i,
    input  logic                                  tx_valid_i,
    output logic                                  tx_ready_o,
    input  hyper_pkg::hyper_tx_t                  tx_i,
    output logic                                  rx_valid_o,
    input  logic                                  rx_ready_i,
    output hyper_pkg::hyper_rx_t                  rx_o,
    output logic                                  b_valid_o,
    input  logic                                  b_ready_i,
    output logic                                  b_error_o,
    output logic [1:0][hyper_pkg::NumChips-1:0]   hyper_cs_no,
    output logic [1:0]                            hyper_ck_o,
    output logic [1:0]                            hyper_rwds_o,
    input  logic [1:0]                            hyper_rwds_i,
    output logic [1:0]                            hyper_rwds_oe_o,
    output logic [1:0][7:0]                       hyper_dq_o,
    input  logic [1:0][7:0]                       hyper_dq_i,
    output logic [1:0]                            hyper_dq_oe_o,
    output logic [1:0]                            hyper_reset_no
);
    import hyper_pkg::*;

    logic [1:0]     lane_trans_ready;
    logic [1:0]     lane_tx_ready;
    logic [1:0]     lane_rx_valid;
    logic [1:0]     fifo_in_ready;
    logic [1:0]     fifo_valid;
    logic [1:0]     lane_b_valid;
    logic [1:0]     lane_b_error;
    lane_rx_t [1:0] lane_rx;
    lane_rx_t [1:0] fifo_rx;
    logic           lane_trans_valid;
    logic           lane_tx_valid;
    logic           fifo_ready;
    logic           lane_b_ready;

    // Device reset follows the system reset
    assign hyper_reset_no = {2{arst_n_i}};

    for (genvar i = 0; i < 2; i++) begin : g_lane
        hyper_lane i_lane (
            .clk_i         (clk_i),
            .arst_n_i      (arst_n_i),
            .cfg_i         (cfg_i),
            .trans_valid_i (lane_trans_valid),
            .trans_ready_o (lane_trans_ready[i]),
            .trans_i       (trans_i),
            .trans_cs_i    (trans_cs_i),
            .tx_valid_i    (lane_tx_valid),
            .tx_ready_o    (lane_tx_ready[i]),
            .tx_i          ({tx_i.data[16*i +: 16], tx_i.strb[2*i +: 2], tx_i.last}),
            .rx_valid_o    (lane_rx_valid[i]),
            .rx_ready_i    (fifo_in_ready[i]),
            .rx_o          (lane_rx[i]),
            .b_valid_o     (lane_b_valid[i]),
            .b_ready_i     (lane_b_ready),
            .b_error_o     (lane_b_error[i]),
            .cs_no         (hyper_cs_no[i]),
            .ck_o          (hyper_ck_o[i]),
            .rwds_o        (hyper_rwds_o[i]),
            .rwds_i        (hyper_rwds_i[i]),
            .rwds_oe_o     (hyper_rwds_oe_o[i]),
            .dq_o          (hyper_dq_o[i]),
            .dq_i          (hyper_dq_i[i]),
            .dq_oe_o       (hyper_dq_oe_o[i])
        );

        hyper_rx_fifo i_rx_fifo (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .valid_i  (lane_rx_valid[i]),
            .ready_o  (fifo_in_ready[i]),
            .data_i   (lane_rx[i]),
            .valid_o  (fifo_valid[i]),
            .ready_i  (fifo_ready),
            .data_o   (fifo_rx[i])
        );
    end

    hyper_lane_join i_join (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .trans_valid_i      (trans_valid_i),
        .trans_ready_o      (trans_ready_o),
        .lane_trans_ready_i (lane_trans_ready),
        .lane_trans_valid_o (lane_trans_valid),
        .tx_valid_i         (tx_valid_i),
        .tx_ready_o         (tx_ready_o),
        .lane_tx_ready_i    (lane_tx_ready),
        .lane_tx_valid_o    (lane_tx_valid),
        .fifo_valid_i       (fifo_valid),
        .fifo_rx_i          (fifo_rx),
        .fifo_ready_o       (fifo_ready),
        .rx_valid_o         (rx_valid_o),
        .rx_ready_i         (rx_ready_i),
        .rx_o               (rx_o),
        .lane_b_valid_i     (lane_b_valid),
        .lane_b_error_i     (lane_b_error),
        .lane_b_ready_o     (lane_b_ready),
        .b_valid_o          (b_valid_o),
        .b_ready_i          (b_ready_i),
        .b_error_o          (b_error_o)
    );

endmodule

//--- src/hyper_lane_join.sv
// Merges the handshakes and data of the two lanes into single 32-bit channels
`timescale 1ns/1ps

module hyper_lane_join (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      trans_valid_i,
    output logic                      trans_ready_o,
    input  logic [1:0]                lane_trans_ready_i,
    output logic                      lane_trans_valid_o,
    input  logic                      tx_valid_i,
    output logic                      tx_ready_o,
    input  logic [1:0]                lane_tx_ready_i,
    output logic                      lane_tx_valid_o,
    input  logic [1:0]                fifo_valid_i,
    input  hyper_pkg::lane_rx_t [1:0] fifo_rx_i,
    output logic                      fifo_ready_o,
    output logic                      rx_valid_o,
    input  logic                      rx_ready_i,
    output hyper_pkg::hyper_rx_t      rx_o,
    input  logic [1:0]                lane_b_valid_i,
    input  logic [1:0]                lane_b_error_i,
    output logic                      lane_b_ready_o,
    output logic                      b_valid_o,
    input  logic                      b_ready_i,
    output logic                      b_error_o
);

    // Lanes only see a handshake once both of them can take it
    assign trans_ready_o      = &lane_trans_ready_i;
    assign lane_trans_valid_o = trans_valid_i && trans_ready_o;
    assign tx_ready_o         = &lane_tx_ready_i;
    assign lane_tx_valid_o    = tx_valid_i && tx_ready_o;

    // Both FIFOs pop together
    assign rx_valid_o   = &fifo_valid_i;
    assign fifo_ready_o = rx_ready_i && rx_valid_o;
    assign rx_o.data    = {fifo_rx_i[1].data, fifo_rx_i[0].data};
    assign rx_o.error   = fifo_rx_i[0].error || fifo_rx_i[1].error;
    assign rx_o.last    = fifo_rx_i[0].last && fifo_rx_i[1].last;

    assign b_valid_o      = &lane_b_valid_i;
    assign lane_b_ready_o = b_ready_i && b_valid_o;
    assign b_error_o      = |lane_b_error_i;

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        &fifo_valid_i |-> (fifo_rx_i[0].last == fifo_rx_i[1].last));

    // Lanes run in lockstep, so their responses line up
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        lane_b_valid_i[0] |-> lane_b_valid_i[1] && (lane_b_error_i[0] == lane_b_error_i[1]));

endmodule

//--- src/hyper_rx_fifo.sv
// Read FIFO behind one lane; registered output with valid/ready on both sides
`timescale 1ns/1ps

module hyper_rx_fifo (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                valid_i,
    output logic                ready_o,
    input  hyper_pkg::lane_rx_t data_i,
    output logic                valid_o,
    input  logic                ready_i,
    output hyper_pkg::lane_rx_t data_o
);
    import hyper_pkg::*;

    // Depth is a power of two, so pointers wrap on their own
    lane_rx_t                       mem_q [FifoDepth];
    logic [$clog2(FifoDepth)-1:0]   wptr_q;
    logic [$clog2(FifoDepth)-1:0]   rptr_q;
    logic [$clog2(FifoDepth):0]     count_q;
    logic                           push;
    logic                           pop;

    assign ready_o = (count_q != FifoDepth);
    assign valid_o = (count_q != 0);
    assign data_o  = mem_q[rptr_q];
    assign push    = valid_i && ready_o;
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop) begin
                rptr_q <= rptr_q + 1'b1;
            end
            count_q <= count_q + push - pop;
        end
    end

    // A full FIFO with no pop must not take another entry
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (count_q == FifoDepth && !ready_i) |=> $stable(wptr_q));

endmodule

//--- src/hyper_lane.sv
// Single HyperBus lane engine; runs command, latency and data phases for one 16-bit half
`timescale 1ns/1ps

module hyper_lane (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    input  hyper_pkg::hyper_cfg_t            cfg_i,
    input  logic                             trans_valid_i,
    output logic                             trans_ready_o,
    input  hyper_pkg::hyper_tf_t             trans_i,
    input  logic [hyper_pkg::NumChips-1:0]   trans_cs_i,
    input  logic                             tx_valid_i,
    output logic                             tx_ready_o,
    input  hyper_pkg::lane_tx_t              tx_i,
    output logic                             rx_valid_o,
    input  logic                             rx_ready_i,
    output hyper_pkg::lane_rx_t              rx_o,
    output logic                             b_valid_o,
    input  logic                             b_ready_i,
    output logic                             b_error_o,
    output logic [hyper_pkg::NumChips-1:0]   cs_no,
    output logic                             ck_o,
    output logic                             rwds_o,
    input  logic                             rwds_i,
    output logic                             rwds_oe_o,
    output logic [7:0]                       dq_o,
    input  logic [7:0]                       dq_i,
    output logic                             dq_oe_o
);
    import hyper_pkg::*;

    lane_state_e             state_q;
    logic [CaBytes*8-1:0]    ca_q;
    logic [3:0]              cnt_q;
    burst_t                  word_q;
    burst_t                  burst_q;
    logic [7:0]              tmo_q;
    logic [7:0]              lo_q;
    logic                    write_q;
    logic                    timed_out_q;
    logic                    byte_q;
    logic                    hold_v_q;
    lane_tx_t                hold_q;
    logic                    slot_free;
    logic                    wr_fin;
    logic                    rd_last;
    logic                    tx_acc;
    logic                    rx_load;
    logic                    fin;

    assign trans_ready_o = (state_q == IDLE);
    assign tx_ready_o    = (state_q == WRITE) && (!hold_v_q || (byte_q && !wr_fin));
    assign tx_acc        = tx_valid_i && tx_ready_o;
    assign slot_free     = !rx_valid_o || rx_ready_i;
    assign wr_fin        = hold_q.last || (word_q == burst_q);
    assign rd_last       = (word_q == burst_q);
    assign b_valid_o     = (state_q == RESP) && write_q;
    assign dq_oe_o       = (state_q == CMD) || (state_q == WRITE);
    assign rwds_oe_o     = (state_q == WRITE);

    // Timed-out reads fill the remaining beats without clocking the device
    assign rx_load = (state_q == READ)
                     && (timed_out_q ? slot_free : (ck_o && rwds_i && byte_q));
    assign fin     = ((state_q == WRITE) && hold_v_q && byte_q && wr_fin)
                     || (rx_load && rd_last);

    // Bus clock stops when a write beat is missing or the read FIFO is full
    always_comb begin
        case (state_q)
            CMD, LATENCY: ck_o = 1'b1;
            WRITE:        ck_o = hold_v_q;
            READ:         ck_o = !timed_out_q && slot_free;
            default:      ck_o = 1'b0;
        endcase
    end

    // Low byte goes first, rwds carries the byte mask
    always_comb begin
        dq_o   = '0;
        rwds_o = 1'b0;
        if (state_q == CMD) begin
            dq_o = ca_q[CaBytes*8-1 -: 8];
        end else if (state_q == WRITE) begin
            dq_o   = byte_q ? hold_q.data[15:8] : hold_q.data[7:0];
            rwds_o = ~hold_q.strb[byte_q];
        end
    end

    always_ff @(posedge clk_i) begin
        if (trans_valid_i && trans_ready_o) begin
            // Command bytes: write flag, word address, burst length
            ca_q    <= {trans_i.write, 7'b0, trans_i.addr, trans_i.burst};
            write_q <= trans_i.write;
            burst_q <= trans_i.burst;
        end else if (state_q == CMD) begin
            ca_q <= ca_q << 8;
        end
        if (tx_acc) begin
            hold_q <= tx_i;
        end
        if (ck_o && rwds_i && !byte_q) begin
            lo_q <= dq_i;
        end
        if (rx_load) begin
            rx_o.data  <= timed_out_q ? '0 : {dq_i, lo_q};
            rx_o.last  <= rd_last;
            rx_o.error <= timed_out_q;
        end
        if (fin && state_q == WRITE) begin
            b_error_o <= hold_q.last != (word_q == burst_q);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            cs_no       <= '1;
            cnt_q       <= '0;
            word_q      <= '0;
            tmo_q       <= '0;
            timed_out_q <= 1'b0;
            byte_q      <= 1'b0;
            hold_v_q    <= 1'b0;
            rx_valid_o  <= 1'b0;
        end else begin
            hold_v_q <= tx_acc || (hold_v_q && !byte_q);
            if (rx_load) begin
                rx_valid_o <= 1'b1;
                word_q     <= word_q + 1'b1;
            end else if (rx_ready_i) begin
                rx_valid_o <= 1'b0;
            end
            case (state_q)
                IDLE: if (trans_valid_i) begin
                    state_q     <= CMD;
                    cs_no       <= ~trans_cs_i;
                    cnt_q       <= '0;
                    word_q      <= '0;
                    tmo_q       <= '0;
                    timed_out_q <= 1'b0;
                    byte_q      <= 1'b0;
                end
                CMD: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CaBytes - 1) begin
                        cnt_q   <= '0;
                        state_q <= LATENCY;
                    end
                end
                LATENCY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q + 4'd1 >= cfg_i.latency) begin
                        state_q <= write_q ? WRITE : READ;
                    end
                end
                WRITE: if (hold_v_q) begin
                    byte_q <= ~byte_q;
                    if (byte_q) begin
                        word_q <= word_q + 1'b1;
                    end
                end
                READ: if (!timed_out_q && ck_o) begin
                    if (rwds_i) begin
                        tmo_q  <= '0;
                        byte_q <= ~byte_q;
                    end else begin
                        tmo_q <= tmo_q + 1'b1;
                        if (tmo_q == cfg_i.timeout) begin
                            timed_out_q <= 1'b1;
                        end
                    end
                end
                RESP: if (write_q ? b_ready_i : !rx_valid_o) begin
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
            if (fin) begin
                state_q <= RESP;
                cs_no   <= '1;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i) (state_q == IDLE) |-> &cs_no);
    assert property (@(posedge clk_i) disable iff (!arst_n_i) (state_q == READ) |-> !dq_oe_o);

endmodule

//--- src/hyper_pkg.sv
// Shared constants, width types, channel structs and lane FSM states for the HyperBus controller
package hyper_pkg;

    localparam int unsigned NumChips  = 2;
    localparam int unsigned FifoDepth = 4;
    localparam int unsigned CaBytes   = 6;

    typedef logic [31:0] addr_t;
    typedef logic [7:0]  burst_t;
    typedef logic [15:0] half_t;

    typedef struct packed {
        logic [3:0] latency;
        logic [7:0] timeout;
    } hyper_cfg_t;

    typedef struct packed {
        logic   write;
        addr_t  addr;
        burst_t burst;
    } hyper_tf_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } hyper_tx_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
        logic        error;
    } hyper_rx_t;

    // One lane carries one 16-bit half of each word
    typedef struct packed {
        half_t      data;
        logic [1:0] strb;
        logic       last;
    } lane_tx_t;

    typedef struct packed {
        half_t data;
        logic  last;
        logic  error;
    } lane_rx_t;

    typedef enum logic [2:0] {IDLE, CMD, LATENCY, WRITE, READ, RESP} lane_state_e;

endpackage
